/* common/rv_ctrl_pkg.sv */
`default_nettype none

package rv_ctrl_pkg;

    import rv_isa_pkg::*;

    typedef struct packed {
        imm_sel_e    imm_sel;
        branch_sel_e branch_sel;
        wb_sel_e     wb_sel;
        alu_sel_e    alu_sel;
        logic        alu_src_pc;  // Operand a is the PC
        logic        alu_src_imm; // Operand b is the immediate
        logic        reg_write;
        logic        mem_write;
    } ctrl_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    next_pc;
        logic     rd_write;
        reg_idx_t rd;
        word_t    rd_data;
    } retire_t;

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        ACK
    } seq_state_e;

endpackage

`default_nettype wire

/* common/rv_isa_pkg.sv */
`default_nettype none

`include "rv_macros.svh"

package rv_isa_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0]          reg_idx_t;
    typedef logic [31:0]         instr_t;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        IMM_I    = 3'b000,
        IMM_S    = 3'b001,
        IMM_B    = 3'b010,
        IMM_U    = 3'b011,
        IMM_J    = 3'b100,
        IMM_NONE = 3'b101,
        IMM_ZERO = 3'b111
    } imm_sel_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'b000,
        BR_JUMP = 3'b001,
        BR_BEQ  = 3'b010,
        BR_BNE  = 3'b011,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branch_sel_e;

    typedef enum logic [1:0] {
        WB_PC4 = 2'b00,
        WB_ALU = 2'b01,
        WB_IMM = 2'b10,
        WB_MEM = 2'b11
    } wb_sel_e;

    // Codes 10 to 17 stay free for the M extension
    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_SLL  = 5'd2,
        ALU_SLT  = 5'd3,
        ALU_SLTU = 5'd4,
        ALU_XOR  = 5'd5,
        ALU_SRL  = 5'd6,
        ALU_SRA  = 5'd7,
        ALU_OR   = 5'd8,
        ALU_AND  = 5'd9
    } alu_sel_e;

endpackage

`default_nettype wire

/* common/rv_macros.svh */
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Data path width
`define RV_XLEN 32

// Architectural registers x0..x31
`define RV_REG_COUNT 32

// Data RAM depth in words
`define RV_DMEM_WORDS 64

// First PC after reset
`define RV_RESET_PC 32'h0000_0000

`endif

/* decode/control_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module control_unit
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  instr_t instr,
    output ctrl_t  ctrl
);

    opcode_e    opcode;
    logic [2:0] func_3;
    logic [6:0] func_7;
    alu_sel_e   f3_alu;

    assign opcode = opcode_e'(instr[6:0]);
    assign func_3 = instr[14:12];
    assign func_7 = instr[31:25];

    // Base operation for OP and OP_IMM by func_3
    always_comb begin
        case (func_3)
            3'b000:  f3_alu = ALU_ADD;
            3'b001:  f3_alu = ALU_SLL;
            3'b010:  f3_alu = ALU_SLT;
            3'b011:  f3_alu = ALU_SLTU;
            3'b100:  f3_alu = ALU_XOR;
            3'b101:  f3_alu = ALU_SRL;
            3'b110:  f3_alu = ALU_OR;
            default: f3_alu = ALU_AND;
        endcase
    end

    always_comb begin
        // Illegal by default, writes nothing
        ctrl = '{imm_sel: IMM_NONE, branch_sel: BR_NONE, wb_sel: WB_ALU, alu_sel: ALU_ADD,
                 alu_src_pc: 1'b0, alu_src_imm: 1'b1, reg_write: 1'b0, mem_write: 1'b0};
        case (opcode)
            OPC_LUI: begin
                ctrl.imm_sel   = IMM_U;
                ctrl.wb_sel    = WB_IMM;
                ctrl.reg_write = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.imm_sel    = IMM_U;
                ctrl.alu_src_pc = 1'b1;
                ctrl.reg_write  = 1'b1;
            end
            OPC_JAL: begin
                ctrl.imm_sel    = IMM_J;
                ctrl.branch_sel = BR_JUMP;
                ctrl.wb_sel     = WB_PC4;
                ctrl.alu_src_pc = 1'b1;
                ctrl.reg_write  = 1'b1;
            end
            OPC_JALR: begin
                if (func_3 == 3'b000) begin
                    ctrl.imm_sel    = IMM_I;
                    ctrl.branch_sel = BR_JUMP;
                    ctrl.wb_sel     = WB_PC4;
                    ctrl.reg_write  = 1'b1;
                end else begin
                    ctrl.imm_sel = IMM_ZERO;
                end
            end
            OPC_BRANCH: begin
                ctrl.imm_sel    = IMM_B;
                ctrl.alu_src_pc = 1'b1; // ALU forms the target
                case (func_3)
                    3'b000:  ctrl.branch_sel = BR_BEQ;
                    3'b001:  ctrl.branch_sel = BR_BNE;
                    3'b100:  ctrl.branch_sel = BR_BLT;
                    3'b101:  ctrl.branch_sel = BR_BGE;
                    3'b110:  ctrl.branch_sel = BR_BLTU;
                    3'b111:  ctrl.branch_sel = BR_BGEU;
                    default: ctrl.branch_sel = BR_NONE;
                endcase
            end
            OPC_LOAD: begin
                ctrl.wb_sel    = WB_MEM;
                ctrl.reg_write = func_3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
                ctrl.imm_sel   = ctrl.reg_write ? IMM_I : IMM_ZERO;
            end
            OPC_STORE: begin
                ctrl.wb_sel    = WB_IMM;
                ctrl.mem_write = func_3 inside {3'b000, 3'b001, 3'b010};
                ctrl.imm_sel   = ctrl.mem_write ? IMM_S : IMM_ZERO;
            end
            OPC_OP_IMM: begin
                ctrl.imm_sel   = IMM_I;
                ctrl.alu_sel   = f3_alu;
                ctrl.reg_write = 1'b1;
                if (func_3 == 3'b001) begin
                    ctrl.reg_write = (func_7 == 7'b0000000);
                end else if (func_3 == 3'b101) begin
                    if (func_7 == 7'b0100000) begin
                        ctrl.alu_sel = ALU_SRA;
                    end
                    ctrl.reg_write = func_7 inside {7'b0000000, 7'b0100000};
                end
            end
            OPC_OP: begin
                ctrl.alu_src_imm = 1'b0;
                ctrl.alu_sel     = f3_alu;
                if (func_7 == 7'b0000000) begin
                    ctrl.reg_write = 1'b1;
                end else if (func_7 == 7'b0100000 && func_3 == 3'b000) begin
                    ctrl.alu_sel   = ALU_SUB;
                    ctrl.reg_write = 1'b1;
                end else if (func_7 == 7'b0100000 && func_3 == 3'b101) begin
                    ctrl.alu_sel   = ALU_SRA;
                    ctrl.reg_write = 1'b1;
                end
            end
            default: ;
        endcase
    end

    // Stores never write back, loads never store
    always_comb begin
        assert final (!(ctrl.reg_write && ctrl.mem_write))
            else $error("control_unit: register and memory write both set");
    end

endmodule

`default_nettype wire

/* decode/imm_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module imm_gen
    import rv_isa_pkg::*;
(
    input  instr_t   instr,
    input  imm_sel_e imm_sel,
    output word_t    imm
);

    always_comb begin
        case (imm_sel)
            IMM_I: imm = {{20{instr[31]}}, instr[31:20]};
            IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            IMM_U: imm = {instr[31:12], 12'b0};
            IMM_J: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: imm = '0; // NONE and ZERO
        endcase
    end

endmodule

`default_nettype wire

/* rv_core.f */
+incdir+common
common/rv_isa_pkg.sv
common/rv_ctrl_pkg.sv
decode/control_unit.sv
decode/imm_gen.sv
src/alu.sv
src/reg_file.sv
src/data_ram.sv
src/core_sequencer.sv
src/rv_core_top.sv
test/tb_rv_core.sv

/* src/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu
    import rv_isa_pkg::*;
(
    input  word_t    a,
    input  word_t    b,
    input  alu_sel_e op,
    output word_t    result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = word_t'($signed(a) < $signed(b));
            ALU_SLTU: result = word_t'(a < b);
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = word_t'($signed(a) >>> shamt);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0; // Reserved M codes
        endcase
    end

endmodule

`default_nettype wire

/* src/core_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_macros.svh"

module core_sequencer
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  wire     clk,
    input  wire     reset,
    input  wire     instr_req,
    input  instr_t  instr,
    input  ctrl_t   ctrl,
    input  word_t   rs1_data,
    input  word_t   rs2_data,
    input  word_t   imm,
    input  word_t   alu_result,
    input  word_t   mem_rdata,
    output logic    instr_ack,
    output instr_t  cur_instr,
    output word_t   pc,
    output logic    rd_write,
    output word_t   rd_data,
    output logic    mem_write,
    output retire_t retire
);

    seq_state_e state;
    logic       taken;
    word_t      pc_plus4;
    word_t      jalr_target;
    word_t      next_pc;

    assign pc_plus4    = pc + word_t'(4);
    assign jalr_target = rs1_data + imm;

    always_comb begin
        case (ctrl.branch_sel)
            BR_JUMP: taken = 1'b1;
            BR_BEQ:  taken = (rs1_data == rs2_data);
            BR_BNE:  taken = (rs1_data != rs2_data);
            BR_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
            BR_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            BR_BLTU: taken = (rs1_data < rs2_data);
            BR_BGEU: taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (taken && cur_instr[6:0] == OPC_JALR) begin
            next_pc = {jalr_target[`RV_XLEN-1:1], 1'b0};
        end else if (taken) begin
            next_pc = alu_result; // PC relative target
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_comb begin
        case (ctrl.wb_sel)
            WB_PC4:  rd_data = pc_plus4;
            WB_ALU:  rd_data = alu_result;
            WB_IMM:  rd_data = imm;
            default: rd_data = mem_rdata;
        endcase
    end

    // Side effects only in the single EXEC cycle
    assign rd_write  = (state == EXEC) && ctrl.reg_write;
    assign mem_write = (state == EXEC) && ctrl.mem_write;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            instr_ack <= 1'b0;
            pc        <= `RV_RESET_PC;
            cur_instr <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (instr_req) begin
                        cur_instr <= instr;
                        state     <= EXEC;
                    end
                end
                EXEC: begin
                    pc        <= next_pc;
                    instr_ack <= 1'b1;
                    state     <= ACK;
                end
                default: begin
                    if (!instr_req) begin // Wait out back-pressure
                        instr_ack <= 1'b0;
                        state     <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= (state == EXEC);
            if (state == EXEC) begin
                retire.pc       <= pc;
                retire.next_pc  <= next_pc;
                retire.rd_write <= ctrl.reg_write;
                retire.rd       <= cur_instr[11:7];
                retire.rd_data  <= rd_data;
            end
        end
    end

    ack_in_ack_a: assert property (@(posedge clk) disable iff (reset)
        instr_ack |-> state == ACK)
        else $error("core_sequencer: instr_ack high outside ACK");

    single_retire_a: assert property (@(posedge clk) disable iff (reset)
        retire.valid |=> !retire.valid)
        else $error("core_sequencer: retire valid held for two cycles");

endmodule

`default_nettype wire

/* src/data_ram.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_macros.svh"

module data_ram
    import rv_isa_pkg::*;
#(
    parameter int WORDS = `RV_DMEM_WORDS
) (
    input  wire        clk,
    input  word_t      addr,
    input  word_t      wdata,
    input  wire        write,
    input  wire  [2:0] size_code,
    output word_t      rdata
);

    localparam int AW = $clog2(WORDS);

    word_t          mem [WORDS];
    logic  [AW-1:0] idx;
    logic  [1:0]    lane;
    word_t          word_rd;
    logic  [7:0]    rd_byte;
    logic  [15:0]   rd_half;

    assign idx  = addr[AW+1:2]; // Upper bits wrap
    assign lane = addr[1:0];

    always_ff @(posedge clk) begin
        if (write) begin
            case (size_code[1:0])
                2'b00:   mem[idx][{lane, 3'b000} +: 8] <= wdata[7:0];
                2'b01:   mem[idx][{lane[1], 4'b0000} +: 16] <= wdata[15:0];
                default: mem[idx] <= wdata;
            endcase
        end
    end

    assign word_rd = mem[idx];
    assign rd_byte = word_rd[{lane, 3'b000} +: 8];
    assign rd_half = word_rd[{lane[1], 4'b0000} +: 16];

    always_comb begin
        case (size_code)
            3'b000:  rdata = {{24{rd_byte[7]}}, rd_byte};   // LB
            3'b001:  rdata = {{16{rd_half[15]}}, rd_half};  // LH
            3'b100:  rdata = {24'b0, rd_byte};              // LBU
            3'b101:  rdata = {16'b0, rd_half};              // LHU
            default: rdata = word_rd;
        endcase
    end

endmodule

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_macros.svh"

module reg_file
    import rv_isa_pkg::*;
(
    input  wire      clk,
    input  wire      reset,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  wire      rd_write,
    input  word_t    rd_data,
    output word_t    rs1_data,
    output word_t    rs2_data
);

    word_t regs [`RV_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_write && rd != '0) begin // x0 stays zero
            regs[rd] <= rd_data;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    zero_reg_a: assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
        else $error("reg_file: x0 holds a non-zero value");

endmodule

`default_nettype wire

/* src/rv_core_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core_top
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  wire     clk,
    input  wire     reset,
    input  wire     instr_req,
    input  instr_t  instr,
    output logic    instr_ack,
    output retire_t retire
);

    instr_t cur_instr;
    ctrl_t  ctrl;
    word_t  imm;
    word_t  pc;
    word_t  rs1_data;
    word_t  rs2_data;
    word_t  alu_a;
    word_t  alu_b;
    word_t  alu_result;
    word_t  mem_rdata;
    word_t  rd_data;
    logic   rd_write;
    logic   mem_write;

    // ALU operand muxes
    assign alu_a = ctrl.alu_src_pc ? pc : rs1_data;
    assign alu_b = ctrl.alu_src_imm ? imm : rs2_data;

    control_unit i_control_unit (.instr(cur_instr), .ctrl(ctrl));

    imm_gen i_imm_gen (.instr(cur_instr), .imm_sel(ctrl.imm_sel), .imm(imm));

    reg_file i_reg_file (
        .clk(clk), .reset(reset),
        .rs1(cur_instr[19:15]), .rs2(cur_instr[24:20]), .rd(cur_instr[11:7]),
        .rd_write(rd_write), .rd_data(rd_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    alu i_alu (.a(alu_a), .b(alu_b), .op(ctrl.alu_sel), .result(alu_result));

    data_ram i_data_ram (
        .clk(clk), .addr(alu_result), .wdata(rs2_data), .write(mem_write),
        .size_code(cur_instr[14:12]), .rdata(mem_rdata)
    );

    core_sequencer i_core_sequencer (
        .clk(clk), .reset(reset), .instr_req(instr_req), .instr(instr),
        .ctrl(ctrl), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
        .alu_result(alu_result), .mem_rdata(mem_rdata),
        .instr_ack(instr_ack), .cur_instr(cur_instr), .pc(pc),
        .rd_write(rd_write), .rd_data(rd_data), .mem_write(mem_write),
        .retire(retire)
    );

endmodule

`default_nettype wire

/* test/tb_rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_macros.svh"

module tb_rv_core
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
();

    localparam int TIMEOUT = 20;

    logic    clk;
    logic    reset;
    logic    instr_req;
    instr_t  instr;
    logic    instr_ack;
    retire_t retire;

    word_t   m_regs [`RV_REG_COUNT]; // Reference model state
    word_t   m_mem [`RV_DMEM_WORDS];
    word_t   m_pc;

    retire_t got;
    string   cur_test;
    int      errors;
    integer  seed;

    rv_core_top i_dut (
        .clk(clk), .reset(reset), .instr_req(instr_req), .instr(instr),
        .instr_ack(instr_ack), .retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic finish_run();
        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("%s: timed out waiting for %s", cur_test, what);
        errors++;
    endtask

    task automatic check_word(input string label, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %h, actual %h", cur_test, label, exp, act);
            errors++;
        end
    endtask

    task automatic check_idx(input string label, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %0d, actual %0d", cur_test, label, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string label, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %b, actual %b", cur_test, label, exp, act);
            errors++;
        end
    endtask

    // Four-phase handshake with one extra cycle of back-pressure before release
    task automatic issue_instr(input instr_t code);
        int edges;
        int cycles;
        @(posedge clk);
        instr_req <= 1'b1;
        instr     <= code;
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end while (!instr_ack && edges < TIMEOUT);
        if (!instr_ack) begin
            report_timeout("instr_ack to rise");
        end else if (edges != 2) begin
            $display("%s: instr_ack rose %0d edges after the request, not 2", cur_test, edges);
            errors++;
        end
        if (retire.valid !== 1'b1) begin
            $display("%s: retire valid was not set together with instr_ack", cur_test);
            errors++;
        end
        got = retire;
        @(posedge clk);
        @(negedge clk);
        if (retire.valid !== 1'b0 || instr_ack !== 1'b1) begin
            $display("%s: core did not hold still while instr_req stayed high", cur_test);
            errors++;
        end
        @(posedge clk);
        instr_req <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (instr_ack && cycles < TIMEOUT);
        if (instr_ack) begin
            report_timeout("instr_ack to fall");
        end
    endtask

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t x, input word_t y);
        case (f3)
            3'b000:  return alt ? x - y : x + y;
            3'b001:  return x << y[4:0];
            3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'b011:  return (x < y) ? 32'd1 : 32'd0;
            3'b100:  return x ^ y;
            3'b101:  return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'b110:  return x | y;
            default: return x & y;
        endcase
    endfunction

    // Architectural behavior of one instruction from the ISA rules
    task automatic model_exec(input instr_t code, output logic wr, output word_t data,
                              output word_t npc);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      imm_s;
        word_t      addr;
        word_t      w;
        logic [7:0] by;
        logic [15:0] hw;
        int         widx;
        logic       take;
        opc   = code[6:0];
        f3    = code[14:12];
        f7    = code[31:25];
        a     = m_regs[code[19:15]];
        b     = m_regs[code[24:20]];
        imm_i = {{20{code[31]}}, code[31:20]};
        imm_s = {{20{code[31]}}, code[31:25], code[11:7]};
        addr  = a + ((opc == OPC_STORE) ? imm_s : imm_i);
        widx  = (addr >> 2) % `RV_DMEM_WORDS;
        w     = m_mem[widx];
        by    = w[addr[1:0] * 8 +: 8];
        hw    = w[addr[1] * 16 +: 16];
        take  = 1'b0;
        wr    = 1'b0;
        data  = '0;
        npc   = m_pc + 32'd4;
        case (opc)
            OPC_LUI: begin
                wr   = 1'b1;
                data = {code[31:12], 12'b0};
            end
            OPC_AUIPC: begin
                wr   = 1'b1;
                data = m_pc + {code[31:12], 12'b0};
            end
            OPC_JAL: begin
                wr   = 1'b1;
                data = m_pc + 32'd4;
                npc  = m_pc + {{12{code[31]}}, code[19:12], code[20], code[30:21], 1'b0};
            end
            OPC_JALR: begin
                if (f3 == 3'b000) begin
                    wr   = 1'b1;
                    data = m_pc + 32'd4;
                    npc  = (a + imm_i) & ~32'd1;
                end
            end
            OPC_BRANCH: begin
                case (f3)
                    3'b000:  take = (a == b);
                    3'b001:  take = (a != b);
                    3'b100:  take = ($signed(a) < $signed(b));
                    3'b101:  take = ($signed(a) >= $signed(b));
                    3'b110:  take = (a < b);
                    3'b111:  take = (a >= b);
                    default: take = 1'b0;
                endcase
                if (take) begin
                    npc = m_pc + {{20{code[31]}}, code[7], code[30:25], code[11:8], 1'b0};
                end
            end
            OPC_LOAD: begin
                wr = f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
                case (f3)
                    3'b000:  data = {{24{by[7]}}, by};
                    3'b001:  data = {{16{hw[15]}}, hw};
                    3'b100:  data = {24'b0, by};
                    3'b101:  data = {16'b0, hw};
                    default: data = w;
                endcase
            end
            OPC_STORE: begin
                if (f3 == 3'b000) begin
                    m_mem[widx][addr[1:0] * 8 +: 8] = b[7:0];
                end else if (f3 == 3'b001) begin
                    m_mem[widx][addr[1] * 16 +: 16] = b[15:0];
                end else if (f3 == 3'b010) begin
                    m_mem[widx] = b;
                end
            end
            OPC_OP_IMM: begin
                if (f3 == 3'b001) begin
                    wr = (f7 == 7'b0000000);
                end else if (f3 == 3'b101) begin
                    wr = (f7 == 7'b0000000 || f7 == 7'b0100000);
                end else begin
                    wr = 1'b1;
                end
                data = alu_ref(f3, f3 == 3'b101 && f7[5], a, imm_i);
            end
            OPC_OP: begin
                wr   = (f7 == 7'b0000000) || (f7 == 7'b0100000 && f3 inside {3'b000, 3'b101});
                data = alu_ref(f3, f7[5], a, b);
            end
            default: ;
        endcase
        if (wr && code[11:7] != 5'd0) begin
            m_regs[code[11:7]] = data;
        end
        m_pc = npc;
    endtask

    function automatic instr_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input reg_idx_t rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic instr_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic instr_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic instr_t enc_b(input logic [12:0] off, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic instr_t enc_j(input logic [20:0] off, input reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic instr_t enc_u(input logic [19:0] imm, input reg_idx_t rd,
                                     input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    task automatic run_instr(input instr_t code);
        logic  wr;
        word_t data;
        word_t npc;
        word_t pc_before;
        pc_before = m_pc;
        model_exec(code, wr, data, npc);
        issue_instr(code);
        check_word("pc", pc_before, got.pc);
        check_word("next_pc", npc, got.next_pc);
        check_flag("rd_write", wr, got.rd_write);
        check_idx("rd", code[11:7], got.rd);
        if (wr) begin
            check_word("rd_data", data, got.rd_data);
        end
    endtask

    // LUI then ADDI with the upper part rounded for the signed low part
    task automatic load_reg(input reg_idx_t rd, input word_t value);
        word_t hi;
        hi = (value + 32'h800) >> 12;
        run_instr(enc_u(hi[19:0], rd, OPC_LUI));
        run_instr(enc_i(value[11:0], rd, 3'b000, rd, OPC_OP_IMM));
    endtask

    task automatic test_reset();
        cur_test = "test_reset";
        @(negedge clk);
        if (instr_ack !== 1'b0 || retire.valid !== 1'b0) begin
            $display("%s: instr_ack or retire valid not low after reset", cur_test);
            errors++;
        end
        run_instr(enc_i(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
        check_word("pc", `RV_RESET_PC, got.pc);
    endtask

    task automatic test_alu_ops();
        logic [11:0] imm;
        cur_test = "test_alu_ops";
        for (int r = 1; r <= 4; r++) begin
            load_reg(reg_idx_t'(r), $random(seed));
        end
        for (int f = 0; f < 8; f++) begin
            imm = $random(seed);
            if (f == 1 || f == 5) begin
                imm[11:5] = 7'b0; // Shift amount only
            end
            run_instr(enc_i(imm, 5'd1, f[2:0], reg_idx_t'(8 + f), OPC_OP_IMM));
            run_instr(enc_r(7'b0, 5'd2, 5'd3, f[2:0], reg_idx_t'(16 + f), OPC_OP));
        end
        run_instr(enc_i({7'b0100000, 5'd13}, 5'd4, 3'b101, 5'd24, OPC_OP_IMM)); // SRAI
        run_instr(enc_r(7'b0100000, 5'd4, 5'd1, 3'b000, 5'd25, OPC_OP));        // SUB
        run_instr(enc_r(7'b0100000, 5'd4, 5'd1, 3'b101, 5'd26, OPC_OP));        // SRA
        run_instr(enc_i(12'h123, 5'd2, 3'b000, 5'd0, OPC_OP_IMM));
        run_instr(enc_r(7'b0, 5'd0, 5'd0, 3'b000, 5'd27, OPC_OP));
        check_word("rd_data", 32'h0, got.rd_data); // x0 still zero
    endtask

    task automatic test_jumps_upper();
        word_t rnd;
        cur_test = "test_jumps_upper";
        rnd = $random(seed);
        run_instr(enc_u(rnd[31:12], 5'd7, OPC_LUI));
        run_instr(enc_u(rnd[19:0], 5'd8, OPC_AUIPC));
        run_instr(enc_j(21'd24, 5'd9));
        run_instr(enc_j(21'h1f_fff8, 5'd9)); // Backward by 8
        run_instr(enc_i(12'h101, 5'd0, 3'b000, 5'd11, OPC_OP_IMM));
        run_instr(enc_i(12'h02e, 5'd11, 3'b000, 5'd10, OPC_JALR));
        check_word("next_pc", 32'h0000_012e, got.next_pc);
        run_instr(enc_i(12'hff1, 5'd10, 3'b000, 5'd10, OPC_JALR));
    endtask

    task automatic test_branches();
        logic [2:0] conds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        cur_test = "test_branches";
        for (int i = 0; i < 6; i++) begin
            load_reg(5'd12, $random(seed));
            load_reg(5'd13, $random(seed));
            run_instr(enc_b(13'd16, 5'd13, 5'd12, conds[i]));
            run_instr(enc_b(13'h1ff4, 5'd13, 5'd12, conds[i]));
            run_instr(enc_b(13'd20, 5'd12, 5'd12, conds[i])); // Equal operands
        end
    endtask

    task automatic test_load_store();
        cur_test = "test_load_store";
        load_reg(5'd14, 32'h40);
        load_reg(5'd15, $random(seed));
        run_instr(enc_s(12'd0, 5'd15, 5'd14, 3'b010));
        run_instr(enc_i(12'd0, 5'd14, 3'b010, 5'd19, OPC_LOAD));
        for (int lane = 0; lane < 4; lane++) begin
            if (lane[0]) begin
                load_reg(5'd16, $random(seed) & 32'hffff_7f7f);
            end else begin
                load_reg(5'd16, $random(seed) | 32'h0000_8080);
            end
            run_instr(enc_s(12'(lane), 5'd16, 5'd14, 3'b000));      // SB
            run_instr(enc_i(12'(lane), 5'd14, 3'b000, 5'd17, OPC_LOAD)); // LB
            run_instr(enc_i(12'(lane), 5'd14, 3'b100, 5'd18, OPC_LOAD)); // LBU
        end
        for (int half = 0; half < 4; half += 2) begin
            load_reg(5'd16, $random(seed) | 32'h0000_8000);
            run_instr(enc_s(12'(half), 5'd16, 5'd14, 3'b001));      // SH
            run_instr(enc_i(12'(half), 5'd14, 3'b001, 5'd17, OPC_LOAD)); // LH
            run_instr(enc_i(12'(half), 5'd14, 3'b101, 5'd18, OPC_LOAD)); // LHU
        end
        run_instr(enc_i(12'd0, 5'd14, 3'b010, 5'd19, OPC_LOAD));
    endtask

    task automatic test_illegal();
        word_t kept;
        cur_test = "test_illegal";
        load_reg(5'd20, 32'h80);
        load_reg(5'd21, $random(seed));
        load_reg(5'd22, $random(seed));
        kept = m_regs[21];
        run_instr(enc_s(12'd0, 5'd21, 5'd20, 3'b010));
        run_instr(enc_r(7'b0000010, 5'd21, 5'd20, 3'b000, 5'd23, OPC_OP)); // Bad func_7
        run_instr(enc_r(7'b0000001, 5'd21, 5'd20, 3'b000, 5'd23, OPC_OP)); // MUL
        run_instr(enc_i(12'h010, 5'd20, 3'b001, 5'd23, OPC_JALR));
        run_instr(enc_s(12'd0, 5'd22, 5'd20, 3'b011));
        run_instr({20'habcde, 5'd23, 7'b0001011});                         // Unknown opcode
        run_instr(enc_i(12'd0, 5'd20, 3'b010, 5'd24, OPC_LOAD));
        check_word("rd_data", kept, got.rd_data);
        run_instr(enc_r(7'b0, 5'd0, 5'd23, 3'b000, 5'd25, OPC_OP)); // x23 untouched
    endtask

    initial begin
        seed      = 36926;
        errors    = 0;
        cur_test  = "setup";
        reset     = 1'b1;
        instr_req = 1'b0;
        instr     = '0;
        m_pc      = `RV_RESET_PC;
        foreach (m_regs[i]) begin
            m_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        test_reset();
        test_alu_ops();
        test_jumps_upper();
        test_branches();
        test_load_store();
        test_illegal();
        finish_run();
    end

endmodule

`default_nettype wire
